/* list.f */
+incdir+dv
hw/switch_pkg.sv
hw/ingress_queue.sv
hw/port_arbiter.sv
hw/frame_forwarder.sv
hw/mac_cam_table.sv
hw/switch_core.sv
dv/tb_switch_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the switch testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f list.f --top-module tb_switch_core \
    -o sim_switch_core > sim.log 2>&1 \
    && ./obj_dir/sim_switch_core >> sim.log 2>&1
cat sim.log
grep -q "Test passed" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }

/* dv/switch_tb_model.svh */
// Reference MAC table, same learn rule as the switch
logic                                   model_valid [cam_depth];
logic   [switch_pkg::mac_width-1:0]     model_key   [cam_depth];
logic   [port_width-1:0]                model_port  [cam_depth];

// Expected egress words, indexed by destination * ports + source
logic   [switch_pkg::word_width-1:0]    expected_words [ports*ports][$];

function automatic logic [ports-1:0] expected_destinations(
    input int                           source_port,
    input logic [switch_pkg::mac_width-1:0] destination_mac,
    input logic [switch_pkg::mac_width-1:0] source_mac
);
    logic                   hit;
    logic [port_width-1:0]  hit_port;
    logic [ports-1:0]       mask;
    int                     slot;
    hit      = 1'b0;
    hit_port = '0;
    slot     = -1;
    // Lookup sees the table from before this frame's learn
    for (int i = 0; i < cam_depth; i++) begin
        if (!hit && model_valid[i] && model_key[i] == destination_mac) begin
            hit      = 1'b1;
            hit_port = model_port[i];
        end
    end
    if (destination_mac[40] || !hit) begin
        mask = ~(ports'(1) << source_port);
    end else if (int'(hit_port) == source_port) begin
        mask = '0;
    end else begin
        mask = ports'(1) << hit_port;
    end
    for (int i = 0; i < cam_depth; i++) begin
        if (slot < 0 && model_valid[i] && model_key[i] == source_mac) begin
            slot = i;
        end
    end
    if (slot >= 0) begin
        model_port[slot] = port_width'(source_port);
    end else begin
        for (int i = 0; i < cam_depth; i++) begin
            if (slot < 0 && !model_valid[i]) begin
                slot = i;
            end
        end
        // Full table, station stays unknown
        if (slot >= 0) begin
            model_valid[slot] = 1'b1;
            model_key[slot]   = source_mac;
            model_port[slot]  = port_width'(source_port);
        end
    end
    return mask;
endfunction

task automatic clear_model();
    for (int i = 0; i < cam_depth; i++) begin
        model_valid[i] = 1'b0;
    end
    for (int k = 0; k < ports * ports; k++) begin
        expected_words[k].delete();
    end
endtask

task automatic check_word(input logic [switch_pkg::word_width-1:0] actual,
                          input logic [switch_pkg::word_width-1:0] expected, input int port);
    if (actual !== expected) begin
        mismatch_count++;
        $display("mismatch at %0t: port %0d word %h, expected %h", $time, port, actual, expected);
    end
endtask

task automatic check_mask(input logic [ports-1:0] actual, input logic [ports-1:0] expected,
                          input string what);
    if (actual !== expected) begin
        mismatch_count++;
        $display("mismatch at %0t: %s is %b, expected %b", $time, what, actual, expected);
    end
endtask

/* dv/tb_switch_core.sv */
`timescale 1ns/1ps
module tb_switch_core;

localparam ports      = 4;
localparam cam_depth  = 8;
localparam port_width = $clog2(ports);

logic                                       clock;
logic                                       reset;
logic   [ports-1:0][switch_pkg::word_width-1:0] port_receive_data;
logic   [ports-1:0]                         port_receive_data_valid;
wire    [ports-1:0]                         port_receive_data_ready;
wire    [switch_pkg::word_width-1:0]        port_transmit_data;
wire    [ports-1:0]                         port_transmit_data_valid;

int     mismatch_count;
int     failure_count;
logic   timed_out;
logic   [switch_pkg::word_width-1:0]        egress_frames [ports][$];

`include "switch_tb_model.svh"

switch_core #(
    .number_of_ports            (ports),
    .receive_queue_depth        (64),
    .cam_table_depth            (cam_depth)
) u_dut (
    .clock                      (clock),
    .reset                      (reset),
    .port_receive_data          (port_receive_data),
    .port_receive_data_valid    (port_receive_data_valid),
    .port_receive_data_ready    (port_receive_data_ready),
    .port_transmit_data         (port_transmit_data),
    .port_transmit_data_valid   (port_transmit_data_valid)
);

always #5 clock = ~clock;

function automatic logic [switch_pkg::mac_width-1:0] station(input int n);
    return 48'h0200_0000_0000 | 48'(n);
endfunction

task automatic apply_reset();
    reset = 1'b1;
    repeat (5) @(posedge clock);
    #1 reset = 1'b0;
    clear_model();
    for (int p = 0; p < ports; p++) begin
        egress_frames[p].delete();
    end
endtask

// Byte 12 carries the source port so egress can be sorted per pair
task automatic send_frame(input int port, input logic [47:0] destination_mac,
                          input logic [47:0] source_mac, input int length);
    logic [switch_pkg::word_width-1:0]  words [$];
    logic [ports-1:0]                   mask;
    logic                               accepted;
    int                                 cycles;
    for (int b = 0; b < length; b++) begin
        if (b < 6) words.push_back({1'b0, destination_mac[47-8*b -: 8]});
        else if (b < 12) words.push_back({1'b0, source_mac[47-8*(b-6) -: 8]});
        else if (b == 12) words.push_back(9'(port));
        else words.push_back({b == length - 1, 8'($urandom)});
    end
    mask = expected_destinations(port, destination_mac, source_mac);
    for (int d = 0; d < ports; d++) begin
        if (mask[d]) begin
            foreach (words[i]) expected_words[d*ports+port].push_back(words[i]);
        end
    end
    foreach (words[i]) begin
        port_receive_data[port]       = words[i];
        port_receive_data_valid[port] = 1'b1;
        accepted = 1'b0;
        cycles   = 0;
        while (!accepted && !timed_out) begin
            @(negedge clock);
            accepted = port_receive_data_ready[port];
            @(posedge clock);
            #1 cycles++;
            if (cycles > 5000) begin
                timed_out = 1'b1;
                failure_count++;
                $display("timeout at %0t: port %0d never became ready", $time, port);
            end
        end
    end
    port_receive_data_valid[port] = 1'b0;
endtask

task automatic send_stream(input int port);
    int destination;
    for (int f = 0; f < 6 && !timed_out; f++) begin
        destination = (port + 1 + $urandom % 3) % ports;
        send_frame(port, station(destination + 1), station(port + 1), 14 + $urandom % 47);
    end
endtask

task automatic wait_drained();
    int     cycles;
    int     quiet;
    logic   pending;
    cycles = 0;
    quiet  = 0;
    while (quiet < 40 && !timed_out) begin
        @(negedge clock);
        pending = port_transmit_data_valid != '0;
        for (int k = 0; k < ports * ports; k++) begin
            if (expected_words[k].size() != 0) pending = 1'b1;
        end
        quiet = pending ? 0 : quiet + 1;
        cycles++;
        if (cycles > 20000) begin
            timed_out = 1'b1;
            failure_count++;
            $display("timeout at %0t: expected egress frames never arrived", $time);
        end
    end
    @(posedge clock);
    #1;
endtask

task automatic compare_frame(input int port);
    int key;
    if (egress_frames[port].size() < 14) begin
        failure_count++;
        $display("frame on port %0d too short at %0t", port, $time);
    end else begin
        key = port * ports + int'(egress_frames[port][12][port_width-1:0]);
        for (int i = 0; i < egress_frames[port].size(); i++) begin
            if (expected_words[key].size() == 0) begin
                failure_count++;
                $display("unexpected egress word on port %0d at %0t", port, $time);
                break;
            end
            check_word(egress_frames[port][i], expected_words[key].pop_front(), port);
        end
    end
    egress_frames[port].delete();
endtask

// Egress collector
always @(negedge clock) begin
    if (!reset) begin
        for (int p = 0; p < ports; p++) begin
            if (port_transmit_data_valid[p]) begin
                egress_frames[p].push_back(port_transmit_data);
                if (port_transmit_data[switch_pkg::last_bit]) compare_frame(p);
            end
        end
    end
end

task automatic run_checks();
    ////////////////////////////////////////
    // 1 to 4: reset, flood, learn, filter
    ////////////////////////////////////////
    @(negedge clock);
    check_mask(port_transmit_data_valid, '0, "egress valid after reset");
    check_mask(port_receive_data_ready, '1, "ingress ready after reset");
    @(posedge clock);
    #1 send_frame(0, station(9), station(1), 20);
    wait_drained();
    if (timed_out) return;
    send_frame(2, station(1), station(3), 18);
    wait_drained();
    send_frame(0, station(3), station(1), 25);
    wait_drained();
    if (timed_out) return;
    send_frame(1, 48'hffff_ffff_ffff, station(2), 16);
    wait_drained();
    send_frame(0, station(1), station(5), 30);
    wait_drained();
    send_frame(3, 48'hffff_ffff_ffff, station(4), 14);
    wait_drained();
    if (timed_out) return;
    // 5: all ports at once
    fork
        send_stream(0);
        send_stream(1);
        send_stream(2);
        send_stream(3);
    join
    wait_drained();
    if (timed_out) return;
    // 6: table full after eight stations
    apply_reset();
    for (int n = 10; n < 18 && !timed_out; n++) begin
        send_frame(n % ports, 48'hffff_ffff_ffff, station(n), 15);
        wait_drained();
    end
    send_frame(1, 48'hffff_ffff_ffff, station(18), 15);
    wait_drained();
    send_frame(0, station(18), station(11), 22);
    wait_drained();
    send_frame(1, station(10), station(13), 17);
    wait_drained();
endtask

initial begin
    clock                   = 1'b0;
    reset                   = 1'b1;
    port_receive_data       = '0;
    port_receive_data_valid = '0;
    mismatch_count          = 0;
    failure_count           = 0;
    timed_out               = 1'b0;
    void'($urandom(32'h6d68));
    apply_reset();
    run_checks();
    $display("checks done: %0d mismatches, %0d other errors", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0 && !timed_out) begin
        $display("Test passed");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule

/* hw/switch_core.sv */
`timescale 1ns/1ps
module switch_core #(
    parameter number_of_ports     = 4,
    parameter receive_queue_depth = 64,
    parameter cam_table_depth     = 8
)(
    input  wire                                                     clock,
    input  wire                                                     reset,
    input  wire     [number_of_ports-1:0][switch_pkg::word_width-1:0] port_receive_data,
    input  wire     [number_of_ports-1:0]                           port_receive_data_valid,

    output wire     [number_of_ports-1:0]                           port_receive_data_ready,
    output wire     [switch_pkg::word_width-1:0]                    port_transmit_data,
    output wire     [number_of_ports-1:0]                           port_transmit_data_valid
);

localparam port_width = $clog2(number_of_ports);

wire    [number_of_ports-1:0]                           frame_available;
wire    [number_of_ports-1:0]                           queue_read;
wire    [number_of_ports-1:0][switch_pkg::word_width-1:0] queue_data;
wire                                                    arbitrate;
wire                                                    grant_valid;
wire    [port_width-1:0]                                grant_port;
wire                                                    learn_enable;
wire    [switch_pkg::mac_width-1:0]                     learn_key;
wire    [port_width-1:0]                                learn_port;
wire                                                    match_enable;
wire    [switch_pkg::mac_width-1:0]                     match_key;
wire                                                    match_valid;
wire    [port_width-1:0]                                match_port;
wire                                                    no_match;

////////////////////////////////////////
// Receive queues
////////////////////////////////////////

genvar i;
generate
    for (i = 0; i < number_of_ports; i = i + 1) begin : port_queue
        ingress_queue #(
            .receive_queue_depth    (receive_queue_depth)
        ) ingress_queue (
            .clock                  (clock),
            .reset                  (reset),
            .receive_data           (port_receive_data[i]),
            .receive_data_valid     (port_receive_data_valid[i]),
            .queue_read             (queue_read[i]),
            .receive_data_ready     (port_receive_data_ready[i]),
            .queue_data             (queue_data[i]),
            .frame_available        (frame_available[i])
        );
    end
endgenerate

////////////////////////////////////////
// Forwarding and address table
////////////////////////////////////////

port_arbiter #(
    .number_of_ports    (number_of_ports)
) port_arbiter (
    .clock              (clock),
    .reset              (reset),
    .frame_available    (frame_available),
    .arbitrate          (arbitrate),
    .grant_valid        (grant_valid),
    .grant_port         (grant_port)
);

frame_forwarder #(
    .number_of_ports            (number_of_ports)
) frame_forwarder (
    .clock                      (clock),
    .reset                      (reset),
    .frame_available            (frame_available),
    .queue_data                 (queue_data),
    .grant_valid                (grant_valid),
    .grant_port                 (grant_port),
    .match_valid                (match_valid),
    .match_port                 (match_port),
    .no_match                   (no_match),
    .queue_read                 (queue_read),
    .arbitrate                  (arbitrate),
    .learn_enable               (learn_enable),
    .learn_key                  (learn_key),
    .learn_port                 (learn_port),
    .match_enable               (match_enable),
    .match_key                  (match_key),
    .port_transmit_data         (port_transmit_data),
    .port_transmit_data_valid   (port_transmit_data_valid)
);

mac_cam_table #(
    .number_of_ports    (number_of_ports),
    .cam_table_depth    (cam_table_depth)
) mac_cam_table (
    .clock              (clock),
    .reset              (reset),
    .learn_enable       (learn_enable),
    .learn_key          (learn_key),
    .learn_port         (learn_port),
    .match_enable       (match_enable),
    .match_key          (match_key),
    .match_valid        (match_valid),
    .match_port         (match_port),
    .no_match           (no_match)
);

endmodule

/* hw/mac_cam_table.sv */
`timescale 1ns/1ps
module mac_cam_table #(
    parameter  number_of_ports = 4,
    parameter  cam_table_depth = 8,
    localparam port_width      = $clog2(number_of_ports)
)(
    input  wire                                 clock,
    input  wire                                 reset,
    input  wire                                 learn_enable,
    input  wire     [switch_pkg::mac_width-1:0] learn_key,
    input  wire     [port_width-1:0]            learn_port,
    input  wire                                 match_enable,
    input  wire     [switch_pkg::mac_width-1:0] match_key,

    output logic                                match_valid,
    output logic    [port_width-1:0]            match_port,
    output logic                                no_match
);

localparam index_width = $clog2(cam_table_depth);

logic   [cam_table_depth-1:0]       entry_valid;
logic   [switch_pkg::mac_width-1:0] entry_key [cam_table_depth];
logic   [port_width-1:0]            entry_port [cam_table_depth];

logic                       learn_hit;
logic                       free_found;
logic                       match_hit;
logic   [index_width-1:0]   learn_index;
logic   [index_width-1:0]   free_index;
logic   [index_width-1:0]   match_index;

// Parallel compare, lowest entry wins
always_comb begin
    learn_hit   = 1'b0;
    free_found  = 1'b0;
    match_hit   = 1'b0;
    learn_index = '0;
    free_index  = '0;
    match_index = '0;
    for (int i = 0; i < cam_table_depth; i++) begin
        if (!learn_hit && entry_valid[i] && entry_key[i] == learn_key) begin
            learn_hit   = 1'b1;
            learn_index = index_width'(i);
        end
        if (!free_found && !entry_valid[i]) begin
            free_found = 1'b1;
            free_index = index_width'(i);
        end
        if (!match_hit && entry_valid[i] && entry_key[i] == match_key) begin
            match_hit   = 1'b1;
            match_index = index_width'(i);
        end
    end
end

always_ff @(posedge clock) begin
    if (reset) begin
        entry_valid <= '0;
        match_valid <= 1'b0;
        no_match    <= 1'b0;
    end else begin
        // Full table drops new stations
        if (learn_enable && !learn_hit && free_found) begin
            entry_valid[free_index] <= 1'b1;
        end
        match_valid <= match_enable;
        no_match    <= match_enable && !match_hit;
    end
end

always_ff @(posedge clock) begin
    if (learn_enable) begin
        if (learn_hit) begin
            // Station moved, refresh its port
            entry_port[learn_index] <= learn_port;
        end else if (free_found) begin
            entry_key[free_index]  <= learn_key;
            entry_port[free_index] <= learn_port;
        end
    end
    if (match_enable) begin
        match_port <= entry_port[match_index];
    end
end

endmodule

/* hw/frame_forwarder.sv */
`timescale 1ns/1ps
module frame_forwarder #(
    parameter  number_of_ports = 4,
    localparam port_width      = $clog2(number_of_ports)
)(
    input  wire                                                     clock,
    input  wire                                                     reset,
    input  wire     [number_of_ports-1:0]                           frame_available,
    input  wire     [number_of_ports-1:0][switch_pkg::word_width-1:0] queue_data,
    input  wire                                                     grant_valid,
    input  wire     [port_width-1:0]                                grant_port,
    input  wire                                                     match_valid,
    input  wire     [port_width-1:0]                                match_port,
    input  wire                                                     no_match,

    output logic    [number_of_ports-1:0]                           queue_read,
    output logic                                                    arbitrate,
    output logic                                                    learn_enable,
    output logic    [switch_pkg::mac_width-1:0]                     learn_key,
    output logic    [port_width-1:0]                                learn_port,
    output logic                                                    match_enable,
    output logic    [switch_pkg::mac_width-1:0]                     match_key,
    output logic    [switch_pkg::word_width-1:0]                    port_transmit_data,
    output logic    [number_of_ports-1:0]                           port_transmit_data_valid
);

localparam count_width = $clog2(switch_pkg::header_bytes);

localparam [2:0] state_idle         = 3'd0;
localparam [2:0] state_grant        = 3'd1;
localparam [2:0] state_header       = 3'd2;
localparam [2:0] state_lookup       = 3'd3;
localparam [2:0] state_send_header  = 3'd4;
localparam [2:0] state_send_payload = 3'd5;

logic   [2:0]                   state;
logic   [port_width-1:0]        source_port;
logic   [count_width-1:0]       header_count;
logic                           header_done;
logic                           lookup_start;
logic   [number_of_ports-1:0]   source_mask;
logic   [number_of_ports-1:0]   chosen_mask;
logic   [number_of_ports-1:0]   destination_mask;
logic   [switch_pkg::word_width-1:0] source_word;

// First byte sits in the top slot
logic   [switch_pkg::header_bytes-1:0][switch_pkg::data_width-1:0] header_buffer;

////////////////////////////////////////
// Queue, arbiter and CAM requests
////////////////////////////////////////

assign source_word  = queue_data[source_port];
assign source_mask  = number_of_ports'(1) << source_port;
assign header_done  = header_count == count_width'(switch_pkg::header_bytes - 1);

assign arbitrate    = (state == state_idle) && |frame_available;
assign queue_read   = (state == state_header || state == state_send_payload) ? source_mask : '0;

assign learn_enable = lookup_start;
assign match_enable = lookup_start;
assign learn_port   = source_port;
assign match_key    = header_buffer[switch_pkg::header_bytes-1 -: switch_pkg::mac_bytes];
assign learn_key    = header_buffer[switch_pkg::mac_bytes-1:0];

// Group address or unknown station floods, own port filters
always_comb begin
    if (header_buffer[switch_pkg::header_bytes-1][0] || no_match) begin
        chosen_mask = ~source_mask;
    end else if (match_port == source_port) begin
        chosen_mask = '0;
    end else begin
        chosen_mask = number_of_ports'(1) << match_port;
    end
end

////////////////////////////////////////
// Sequencing
////////////////////////////////////////

always_ff @(posedge clock) begin
    if (reset) begin
        state                    <= state_idle;
        source_port              <= '0;
        header_count             <= '0;
        lookup_start             <= 1'b0;
        destination_mask         <= '0;
        port_transmit_data_valid <= '0;
    end else begin
        lookup_start             <= 1'b0;
        port_transmit_data_valid <= '0;
        case (state)
            state_idle: begin
                if (|frame_available) begin
                    state <= state_grant;
                end
            end
            state_grant: begin
                header_count <= '0;
                source_port  <= grant_port;
                state        <= grant_valid ? state_header : state_idle;
            end
            state_header: begin
                header_count <= header_count + 1'b1;
                if (header_done) begin
                    lookup_start <= 1'b1;
                    state        <= state_lookup;
                end
            end
            state_lookup: begin
                if (match_valid) begin
                    header_count     <= '0;
                    destination_mask <= chosen_mask;
                    // Filtered frames are drained without replay
                    state <= (chosen_mask == '0) ? state_send_payload : state_send_header;
                end
            end
            state_send_header: begin
                port_transmit_data_valid <= destination_mask;
                header_count             <= header_count + 1'b1;
                if (header_done) begin
                    state <= state_send_payload;
                end
            end
            state_send_payload: begin
                port_transmit_data_valid <= destination_mask;
                if (source_word[switch_pkg::last_bit]) begin
                    state <= state_idle;
                end
            end
            default: state <= state_idle;
        endcase
    end
end

always_ff @(posedge clock) begin
    if (state == state_header) begin
        header_buffer[switch_pkg::header_bytes-1-header_count] <=
            source_word[switch_pkg::data_width-1:0];
    end
    if (state == state_send_header) begin
        port_transmit_data <= {1'b0, header_buffer[switch_pkg::header_bytes-1-header_count]};
    end else begin
        port_transmit_data <= source_word;
    end
end

endmodule

/* hw/port_arbiter.sv */
`timescale 1ns/1ps
module port_arbiter #(
    parameter  number_of_ports = 4,
    localparam port_width      = $clog2(number_of_ports)
)(
    input  wire                             clock,
    input  wire                             reset,
    input  wire     [number_of_ports-1:0]   frame_available,
    input  wire                             arbitrate,

    output logic                            grant_valid,
    output logic    [port_width-1:0]        grant_port
);

logic   [port_width-1:0]    last_grant;
logic   [port_width-1:0]    next_port;
logic                       found;

// Search starts one past the last winner
always_comb begin
    found     = 1'b0;
    next_port = last_grant;
    for (int i = 1; i <= number_of_ports; i++) begin
        if (!found && frame_available[(last_grant + i) % number_of_ports]) begin
            found     = 1'b1;
            next_port = port_width'((last_grant + i) % number_of_ports);
        end
    end
end

assign grant_port = last_grant;

always_ff @(posedge clock) begin
    if (reset) begin
        grant_valid <= 1'b0;
        last_grant  <= port_width'(number_of_ports - 1);
    end else begin
        grant_valid <= arbitrate && found;
        if (arbitrate && found) begin
            last_grant <= next_port;
        end
    end
end

endmodule

/* hw/ingress_queue.sv */
`timescale 1ns/1ps
module ingress_queue #(
    parameter receive_queue_depth = 64
)(
    input  wire                                 clock,
    input  wire                                 reset,
    input  wire     [switch_pkg::word_width-1:0] receive_data,
    input  wire                                 receive_data_valid,
    input  wire                                 queue_read,

    output logic                                receive_data_ready,
    output logic    [switch_pkg::word_width-1:0] queue_data,
    output logic                                frame_available
);

localparam address_width = $clog2(receive_queue_depth);
localparam count_width   = $clog2(receive_queue_depth + 1);

logic   [switch_pkg::word_width-1:0]    queue_memory [receive_queue_depth];
logic   [address_width-1:0]             write_pointer;
logic   [address_width-1:0]             read_pointer;
logic   [count_width-1:0]               word_count;
logic   [count_width-1:0]               frame_count;
logic                                   write_enable;
logic                                   frame_written;
logic                                   frame_read;

function automatic logic [address_width-1:0] advance(input logic [address_width-1:0] pointer);
    return (pointer == address_width'(receive_queue_depth - 1)) ? '0 : pointer + 1'b1;
endfunction

assign receive_data_ready = word_count != count_width'(receive_queue_depth);
assign write_enable       = receive_data_valid && receive_data_ready;
assign frame_written      = write_enable && receive_data[switch_pkg::last_bit];
assign frame_read         = queue_read && queue_data[switch_pkg::last_bit];

// Head word straight out of the buffer
assign queue_data         = queue_memory[read_pointer];
assign frame_available    = frame_count != '0;

always_ff @(posedge clock) begin
    if (write_enable) begin
        queue_memory[write_pointer] <= receive_data;
    end
end

always_ff @(posedge clock) begin
    if (reset) begin
        write_pointer <= '0;
        read_pointer  <= '0;
        word_count    <= '0;
        frame_count   <= '0;
    end else begin
        if (write_enable) begin
            write_pointer <= advance(write_pointer);
        end
        if (queue_read) begin
            read_pointer <= advance(read_pointer);
        end

        case ({write_enable, queue_read})
            2'b10:   word_count <= word_count + 1'b1;
            2'b01:   word_count <= word_count - 1'b1;
            default: word_count <= word_count;
        endcase

        // Complete frames only, counted by their last word
        case ({frame_written, frame_read})
            2'b10:   frame_count <= frame_count + 1'b1;
            2'b01:   frame_count <= frame_count - 1'b1;
            default: frame_count <= frame_count;
        endcase
    end
end

endmodule

/* hw/switch_pkg.sv */
package switch_pkg;

    // Port word: data byte plus last-byte flag on top
    localparam int data_width   = 8;
    localparam int word_width   = data_width + 1;
    localparam int last_bit     = data_width;

    // Addresses at the start of each frame
    localparam int mac_width    = 48;
    localparam int mac_bytes    = 6;
    localparam int header_bytes = 2 * mac_bytes;

endpackage
